// ==== common/acq_pkg.sv ====
// shared widths, sizes and state encodings for the multimeter acquisition core; import by wildcard.
package acq_pkg;

  //////////////////////////////////////////////////
  // data widths.
  //////////////////////////////////////////////////

  // precharge pause length in clocks, loaded by the sequencer.
  typedef logic [24-1:0] count_t;

  // measured value, the number of comparator-high cycles in one aperture.
  typedef logic [24-1:0] sample_t;

  // sample sequence tag, wraps after 255.
  typedef logic [8-1:0] seq_t;

  //////////////////////////////////////////////////
  // converter aperture.
  //////////////////////////////////////////////////

  // length of the measurement window in clocks.
  localparam int APERTURE_CYCLES = 200;
  localparam int APERTURE_W = $clog2(APERTURE_CYCLES + 1);

  // elapsed cycle counter inside the aperture.
  typedef logic [APERTURE_W-1:0] aperture_t;
  localparam aperture_t APERTURE_END = aperture_t'(APERTURE_CYCLES);

  //////////////////////////////////////////////////
  // sample fifo.
  //////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_OCC_W = $clog2(FIFO_DEPTH + 1);

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
  typedef logic [FIFO_OCC_W-1:0] fifo_occ_t;

  // sequencer states, in the order they are normally visited.
  typedef enum logic [1:0] {
    ACQ_IDLE,
    ACQ_LOAD,
    ACQ_PRECHARGE,
    ACQ_MEASURE
  } acq_state_t;

endpackage

// ==== acquisition/sample_acquisition_no_az.sv ====
// free running acquisition sequencer: precharge pause, converter release and result wait.
module sample_acquisition_no_az
  import acq_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,

  // converter reports a finished aperture.
  input  logic   measure_valid,

  // fifo cannot take another sample.
  input  logic   fifo_full,

  // pause length, sampled once per cycle in ACQ_LOAD.
  input  count_t clk_count_precharge,

  // converter held in reset while low.
  output logic   adc_reset_n,

  // one cycle push strobe towards the fifo.
  output logic   store,

  // status led, blinks on alternate samples.
  output logic   led
);

  //////////////////////////////////////////////////
  // state and pause counter.
  //////////////////////////////////////////////////

  acq_state_t state;
  count_t     clk_count_down;

  // a result is taken only when the fifo has room.
  // otherwise the converter stays released and holds its value.
  logic       accept;

  assign accept = (state == ACQ_MEASURE) && measure_valid && !fifo_full;

  // store fires in the same cycle as the accept, while the result is still frozen.
  assign store = accept;

  //////////////////////////////////////////////////
  // sequencer fsm.
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state          <= ACQ_IDLE;
      adc_reset_n    <= 1'b0;
      led            <= 1'b0;
      clk_count_down <= '0;
    end
    else
    begin
      case (state)

        // keep converter in reset, leave on the first clock out of reset.
        ACQ_IDLE:
        begin
          adc_reset_n <= 1'b0;
          state       <= ACQ_LOAD;
        end

        // load the pause and blink the led.
        ACQ_LOAD:
        begin
          clk_count_down <= clk_count_precharge;
          led            <= ~led;
          state          <= ACQ_PRECHARGE;
        end

        // count the pause down to zero, one more cycle is spent on the zero.
        ACQ_PRECHARGE:
        begin
          if (clk_count_down == '0)
          begin
            // release the converter for one aperture.
            adc_reset_n <= 1'b1;
            state       <= ACQ_MEASURE;
          end
          else
          begin
            clk_count_down <= clk_count_down - 1'b1;
          end
        end

        // wait for the result and a free fifo slot.
        ACQ_MEASURE:
        begin
          if (accept)
          begin
            // put converter back in reset and restart the pause.
            adc_reset_n <= 1'b0;
            state       <= ACQ_LOAD;
          end
        end

        default:
        begin
          state <= ACQ_IDLE;
        end

      endcase
    end
  end

endmodule

// ==== adc/adc_aperture_counter.sv ====
// converter controller: counts comparator-high clocks over a fixed aperture after release.
module adc_aperture_counter
  import acq_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,

  // low holds the counters cleared.
  input  logic    adc_reset_n,

  // sampled comparator output.
  input  logic    comparator,

  // high from the end of the aperture until the converter is reset.
  output logic    measure_valid,

  // number of comparator-high cycles, frozen once the aperture is done.
  output sample_t result
);

  //////////////////////////////////////////////////
  // aperture and high counters.
  //////////////////////////////////////////////////

  // clocks counted so far in the current aperture.
  aperture_t elapsed;

  // comparator-high clocks so far.
  sample_t   high_count;

  // counting runs while released and the window is still open.
  logic      counting;

  // window closed, counters hold.
  logic      done;

  assign done     = (elapsed == APERTURE_END);
  assign counting = adc_reset_n && !done;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      elapsed    <= '0;
      high_count <= '0;
    end
    else if (!adc_reset_n)
    begin
      // converter in reset, start over.
      elapsed    <= '0;
      high_count <= '0;
    end
    else if (counting)
    begin
      elapsed    <= elapsed + 1'b1;
      high_count <= high_count + sample_t'(comparator);
    end
  end

  //////////////////////////////////////////////////
  // result flag.
  //////////////////////////////////////////////////

  // rises in the cycle after the last counted clock.
  // drops together with adc_reset_n so the sequencer never sees a stale flag.
  assign measure_valid = adc_reset_n && done;

  // high_count no longer moves once done, so it is the frozen result.
  assign result = high_count;

endmodule

// ==== src/sample_fifo.sv ====
// sample buffer: tags each pushed sample with a sequence number and offers it over valid/ready.
module sample_fifo
  import acq_pkg::*;
(
  input  logic    clk,
  input  logic    reset_n,

  // push strobe and the converter result.
  input  logic    store,
  input  sample_t store_data,

  // downstream handshake.
  input  logic    sample_ready,

  output logic    fifo_full,
  output logic    sample_valid,
  output sample_t sample_data,
  output seq_t    sample_seq
);

  //////////////////////////////////////////////////
  // storage and pointers.
  //////////////////////////////////////////////////

  sample_t   data_mem [FIFO_DEPTH];
  seq_t      seq_mem  [FIFO_DEPTH];

  fifo_ptr_t wr_ptr;
  fifo_ptr_t rd_ptr;
  fifo_occ_t occupancy;

  // tag for the next pushed sample.
  seq_t      seq_next;

  logic      pop;

  // a transfer on every clock with valid and ready.
  assign pop          = sample_valid && sample_ready;
  assign sample_valid = (occupancy != '0);
  assign fifo_full    = (occupancy == fifo_occ_t'(FIFO_DEPTH));

  // head entry, stable until popped.
  assign sample_data  = data_mem[rd_ptr];
  assign sample_seq   = seq_mem[rd_ptr];

  // entries carry no reset, only pointers do.
  always_ff @(posedge clk)
  begin
    if (store)
    begin
      data_mem[wr_ptr] <= store_data;
      seq_mem[wr_ptr]  <= seq_next;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
      seq_next  <= '0;
    end
    else
    begin
      if (store)
      begin
        wr_ptr   <= wr_ptr + 1'b1;
        seq_next <= seq_next + 1'b1;
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the occupancy unchanged.
      if (store && !pop)
      begin
        occupancy <= occupancy + 1'b1;
      end
      else if (pop && !store)
      begin
        occupancy <= occupancy - 1'b1;
      end
    end
  end

endmodule

// ==== src/dmm_acq_top.sv ====
// multimeter front end core: sequencer, aperture converter and sample fifo wired to the pins.
module dmm_acq_top
  import acq_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,

  // precharge pause length in clocks.
  input  count_t     clk_count_precharge,

  // comparator output from the analog front end.
  input  logic       comparator,

  // sample stream.
  input  logic       sample_ready,
  output logic       sample_valid,
  output sample_t    sample_data,
  output seq_t       sample_seq,

  output logic       led,

  // bit 0 converter released, bit 1 result valid.
  output logic [1:0] monitor
);

  //////////////////////////////////////////////////
  // internal links.
  //////////////////////////////////////////////////

  logic    adc_reset_n;
  logic    measure_valid;
  logic    fifo_full;
  logic    store;
  sample_t result;

  assign monitor = {measure_valid, adc_reset_n};

  // sequencer, runs freely from reset.
  sample_acquisition_no_az u_seq (
    .clk                 (clk),
    .reset_n             (reset_n),
    .measure_valid       (measure_valid),
    .fifo_full           (fifo_full),
    .clk_count_precharge (clk_count_precharge),
    .adc_reset_n         (adc_reset_n),
    .store               (store),
    .led                 (led)
  );

  // converter controller.
  adc_aperture_counter u_adc (
    .clk           (clk),
    .reset_n       (reset_n),
    .adc_reset_n   (adc_reset_n),
    .comparator    (comparator),
    .measure_valid (measure_valid),
    .result        (result)
  );

  // output buffer.
  sample_fifo u_fifo (
    .clk          (clk),
    .reset_n      (reset_n),
    .store        (store),
    .store_data   (result),
    .sample_ready (sample_ready),
    .fifo_full    (fifo_full),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_seq   (sample_seq)
  );

endmodule

// ==== tests/dmm_acq_chk.sv ====
// assertions bound into the sequencer and the sample fifo to check handshake and sequencing rules.
module dmm_acq_chk
  import acq_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input logic       store,
  input logic       fifo_full,
  input logic       sample_valid,
  input logic       sample_ready,
  input sample_t    sample_data,
  input acq_state_t state,
  input logic       adc_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions in this instance.
  int failures = 0;

  // a push into a full fifo would overwrite the head entry.
  store_not_full: assert property (@(posedge clk) disable iff (!reset_n)
    !(store && fifo_full))
    else
    begin
      $error("store pulsed while the fifo was full");
      failures++;
    end

  // head sample holds while the consumer stalls.
  data_stable: assert property (@(posedge clk) disable iff (!reset_n)
    (sample_valid && !sample_ready) |=> $stable(sample_data))
    else
    begin
      $error("sample_data changed while stalled");
      failures++;
    end

  // converter must stay in reset outside precharge and measure.
  reset_in_idle: assert property (@(posedge clk) disable iff (!reset_n)
    (state == ACQ_IDLE || state == ACQ_LOAD) |-> !adc_reset_n)
    else
    begin
      $error("converter released in idle or load");
      failures++;
    end

endmodule

// on the sequencer side the fifo handshake inputs are tied off.
bind sample_acquisition_no_az dmm_acq_chk seq_chk (
  .clk(clk), .reset_n(reset_n), .store(store), .fifo_full(fifo_full),
  .sample_valid(1'b0), .sample_ready(1'b1), .sample_data('0),
  .state(state), .adc_reset_n(adc_reset_n)
);

// on the fifo side the sequencer state is tied to a state without a rule.
bind sample_fifo dmm_acq_chk fifo_chk (
  .clk(clk), .reset_n(reset_n), .store(store), .fifo_full(fifo_full),
  .sample_valid(sample_valid), .sample_ready(sample_ready), .sample_data(sample_data),
  .state(ACQ_MEASURE), .adc_reset_n(1'b1)
);

// ==== tests/dmm_acq_tb.sv ====
// simulation top that drives the acquisition core with random stimulus and checks every sample.
module dmm_acq_tb
  import acq_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // 20 samples plus the stalled stretch.
  localparam int TIMEOUT_CYCLES = 20 * (APERTURE_CYCLES + 40) + 2000;

  logic       clk;
  logic       reset_n;
  count_t     clk_count_precharge;
  logic       comparator;
  logic       sample_ready;
  logic       sample_valid;
  sample_t    sample_data;
  seq_t       sample_seq;
  logic       led;
  logic [1:0] monitor;

  integer     seed;
  integer     rnd_word;
  logic       backpressure;
  int         errors;
  int         checks;
  int         transfers;
  int         windows;
  int         rising_count;
  int         cycle_count;
  int         mark;

  // expected samples and their tags in window order.
  sample_t    exp_data_q[$];
  seq_t       exp_seq_q[$];

  // window capture state.
  logic       window_bits[$];
  logic       prev_mon0;
  logic       prev_led;
  logic       seen_fall;
  logic       seen_rise;
  count_t     load_p;
  int         low_len;
  int         led_toggles;

  dmm_acq_top UUT (
    .clk(clk), .reset_n(reset_n), .clk_count_precharge(clk_count_precharge),
    .comparator(comparator), .sample_ready(sample_ready), .sample_valid(sample_valid),
    .sample_data(sample_data), .sample_seq(sample_seq), .led(led), .monitor(monitor)
  );

  //////////////////////////////////////////////////
  // helpers.
  //////////////////////////////////////////////////

  // ones among the first aperture bits seen while the converter was released.
  function automatic int aperture_count(input logic bits[$]);
    int n;
    int i;
    n = 0;
    for (i = 0; i < bits.size() && i < APERTURE_CYCLES; i++)
    begin
      if (bits[i] === 1'b1)
      begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("[FAIL] %s: expected %h, got %h", name, expected, got);
    end
  endtask

  task automatic verify_reset_outputs();
    compare_value("sample_valid", sample_valid, 0);
    compare_value("led", led, 0);
    compare_value("monitor", monitor, 0);
  endtask

  //////////////////////////////////////////////////
  // clock and stimulus.
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // random comparator and ready.
  // ready is held low while stalling.
  always @(posedge clk)
  begin
    rnd_word = $random(seed);
    comparator <= rnd_word[0];
    rnd_word = $random(seed);
    sample_ready <= backpressure ? 1'b0 : rnd_word[0];
  end

  //////////////////////////////////////////////////
  // window capture on the falling edge where all is settled.
  //////////////////////////////////////////////////

  initial
  begin
    wait (reset_n === 1'b1);
    @(negedge clk);
    prev_mon0 = monitor[0];
    prev_led = led;
    forever
    begin
      @(negedge clk);
      if (led !== prev_led)
      begin
        led_toggles++;
      end
      if (monitor[0] === 1'b1)
      begin
        // the converter counts this bit on the next rising edge.
        window_bits.push_back(comparator);
        if (prev_mon0 === 1'b0)
        begin
          if (seen_fall)
          begin
            compare_value("precharge low time", low_len, load_p + 2);
          end
          if (seen_rise)
          begin
            compare_value("led toggles per window", led_toggles, 1);
          end
          led_toggles = 0;
          seen_rise = 1'b1;
          rising_count++;
        end
      end
      else
      begin
        // the closed window's result went into the fifo.
        if (prev_mon0 === 1'b1)
        begin
          exp_data_q.push_back(sample_t'(aperture_count(window_bits)));
          exp_seq_q.push_back(seq_t'(windows));
          windows++;
          window_bits.delete();
          seen_fall = 1'b1;
          low_len = 0;
          // ACQ_LOAD samples the pause in the first low cycle.
          load_p = clk_count_precharge;
        end
        low_len++;
      end
      prev_mon0 = monitor[0];
      prev_led = led;
    end
  end

  //////////////////////////////////////////////////
  // comparison at each handshake.
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (reset_n === 1'b1 && sample_valid === 1'b1 && sample_ready === 1'b1)
    begin
      if (exp_data_q.size() == 0)
      begin
        errors++;
        $display("a sample was transferred before any measurement window had finished");
      end
      else
      begin
        compare_value("sample_data", sample_data, exp_data_q.pop_front());
        compare_value("sample_seq", sample_seq, exp_seq_q.pop_front());
      end
      transfers++;
    end
  end

  //////////////////////////////////////////////////
  // reset, phases and end of run.
  //////////////////////////////////////////////////

  initial
  begin
    seed = 89769;
    reset_n = 1'b0;
    clk_count_precharge = count_t'(5);
    comparator = 1'b0;
    sample_ready = 1'b0;
    backpressure = 1'b0;
    seen_fall = 1'b0;
    seen_rise = 1'b0;
    for (int cyc = 1; cyc <= 18; cyc++)
    begin
      @(posedge clk);
      // outputs are unknown until the first reset edge.
      if (cyc > 1)
      begin
        verify_reset_outputs();
      end
      if (cyc == 16)
      begin
        reset_n <= 1'b1;
      end
    end
    wait (transfers >= 6);
    @(posedge clk);
    backpressure <= 1'b1;
    // five windows fill the fifo and the held result well inside this.
    repeat (1500) @(posedge clk);
    mark = rising_count;
    repeat (500)
    begin
      @(posedge clk);
      compare_value("monitor", monitor, 2'b11);
    end
    checks++;
    if (rising_count != mark)
    begin
      errors++;
      $display("a new measurement window started while the fifo was full");
    end
    backpressure <= 1'b0;
    wait (transfers >= 12);
    @(posedge clk);
    clk_count_precharge <= count_t'(12);
    wait (transfers >= 20);
    repeat (4) @(posedge clk);
    errors += UUT.u_seq.seq_chk.failures + UUT.u_fifo.fifo_chk.failures;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    errors += UUT.u_seq.seq_chk.failures + UUT.u_fifo.fifo_chk.failures;
    $display("timeout after %0d cycles with %0d samples received", cycle_count, transfers);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== compile.f ====
common/acq_pkg.sv
acquisition/sample_acquisition_no_az.sv
adc/adc_aperture_counter.sv
src/sample_fifo.sv
src/dmm_acq_top.sv
tests/dmm_acq_chk.sv
tests/dmm_acq_tb.sv

// ==== Bender.yml ====
package:
  name: dmm_acq

sources:
  - common/acq_pkg.sv
  - acquisition/sample_acquisition_no_az.sv
  - adc/adc_aperture_counter.sv
  - src/sample_fifo.sv
  - src/dmm_acq_top.sv
  - target: test
    files:
      - tests/dmm_acq_chk.sv
      - tests/dmm_acq_tb.sv
